//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -sv
TOP       = imuldiv_tb
FILELIST  = compile.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir

//--- compile.f
src/imuldiv_types_pkg.sv
src/imuldiv_msg_pkg.sv
src/imuldiv_req_if.sv
src/imuldiv_int_mul_iterative.sv
src/imuldiv_int_div_iterative.sv
src/imuldiv_iterative_muldiv.sv
test/imuldiv_checker.sv
test/imuldiv_monitor.sv
test/imuldiv_tb.sv

//--- src/imuldiv_int_div_iterative.sv
//--------------------------------------------------------------------------
// iterative restoring divider
// signed or unsigned, one quotient bit per cycle, then one sign-fix cycle
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imuldiv_int_div_iterative (
  input  logic                       clk,
  input  logic                       reset,
  imuldiv_req_if.engine              req,
  output imuldiv_types_pkg::result_t resp_result,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  // control to datapath
  logic req_go;
  logic mag_en;
  logic calc_en;
  logic fix_en;
  logic last_iter;

  // datapath registers
  imuldiv_msg_pkg::fn_t        fn_reg;
  imuldiv_types_pkg::result_t  rq_reg;
  imuldiv_types_pkg::operand_t divisor_reg;
  logic                        sign_a_reg;
  logic                        sign_b_reg;

  // datapath combinational values
  logic                        signed_op;
  imuldiv_types_pkg::operand_t a_mag;
  imuldiv_types_pkg::operand_t b_mag;
  logic [32:0]                 rem_shift;
  imuldiv_types_pkg::operand_t quo_shift;
  logic [33:0]                 diff;
  imuldiv_types_pkg::result_t  rq_next;
  imuldiv_types_pkg::operand_t quo_fix;
  imuldiv_types_pkg::operand_t rem_fix;

  // control registers
  imuldiv_msg_pkg::engine_state_t state;
  imuldiv_types_pkg::count_t      count;
  logic                           load_pending;

  //--------------------------------------------------------------------------
  // datapath
  //--------------------------------------------------------------------------

  // rq_reg holds the partial remainder high and the dividend/quotient low
  assign signed_op = (fn_reg == imuldiv_msg_pkg::fn_div);

  // unsigned divide keeps the raw bit patterns
  assign a_mag = (signed_op & sign_a_reg) ? -rq_reg[31:0] : rq_reg[31:0];
  assign b_mag = (signed_op & sign_b_reg) ? -divisor_reg : divisor_reg;

  // shift the pair left by one, the remainder can briefly need 33 bits
  assign rem_shift = rq_reg[63:31];
  assign quo_shift = {rq_reg[30:0], 1'b0};

  // trial subtract, borrow out in the top bit
  assign diff = {1'b0, rem_shift} - {2'b0, divisor_reg};

  // restore on borrow, else keep the difference and set the quotient bit
  // a zero divisor never borrows, so the quotient fills with ones
  assign rq_next = diff[33] ? {rem_shift[31:0], quo_shift}
                            : {diff[31:0], quo_shift[31:1], 1'b1};

  // quotient sign follows the operand signs, remainder follows the dividend
  assign quo_fix = (signed_op & (sign_a_reg ^ sign_b_reg)) ? -rq_reg[31:0] : rq_reg[31:0];
  assign rem_fix = (signed_op & sign_a_reg) ? -rq_reg[63:32] : rq_reg[63:32];

  always_ff @(posedge clk) begin
    if (req_go) begin
      fn_reg      <= req.fn;
      rq_reg      <= {32'b0, req.a};
      divisor_reg <= req.b;
      sign_a_reg  <= req.a[31];
      sign_b_reg  <= req.b[31];
    end else if (mag_en) begin
      rq_reg      <= {32'b0, a_mag};
      divisor_reg <= b_mag;
    end else if (calc_en) begin
      rq_reg <= rq_next;
    end else if (fix_en) begin
      rq_reg <= {rem_fix, quo_fix};
    end
  end

  // remainder high, quotient low
  assign resp_result = rq_reg;

  //--------------------------------------------------------------------------
  // control
  //--------------------------------------------------------------------------

  assign req.rdy  = (state == imuldiv_msg_pkg::st_idle);
  assign resp_val = (state == imuldiv_msg_pkg::st_done);

  assign req_go    = req.val & req.rdy;
  assign mag_en    = (state == imuldiv_msg_pkg::st_calc) & load_pending;
  assign calc_en   = (state == imuldiv_msg_pkg::st_calc) & ~load_pending;
  assign fix_en    = (state == imuldiv_msg_pkg::st_fix);
  assign last_iter = calc_en & (count == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= imuldiv_msg_pkg::st_idle;
      count        <= '0;
      load_pending <= 1'b0;
    end else begin
      case (state)
        imuldiv_msg_pkg::st_idle: begin
          if (req_go) begin
            state        <= imuldiv_msg_pkg::st_calc;
            load_pending <= 1'b1;
            count        <= imuldiv_types_pkg::count_t'(imuldiv_types_pkg::operand_width - 1);
          end
        end
        imuldiv_msg_pkg::st_calc: begin
          // first cycle is the magnitude load, then one cycle per bit
          if (load_pending) begin
            load_pending <= 1'b0;
          end else if (last_iter) begin
            state <= imuldiv_msg_pkg::st_fix;
          end else begin
            count <= count - imuldiv_types_pkg::count_t'(1);
          end
        end
        imuldiv_msg_pkg::st_fix: begin
          // sign fix takes exactly one cycle, also for unsigned divide
          state <= imuldiv_msg_pkg::st_done;
        end
        imuldiv_msg_pkg::st_done: begin
          if (resp_rdy) begin
            state <= imuldiv_msg_pkg::st_idle;
          end
        end
        default: begin
          state <= imuldiv_msg_pkg::st_idle;
        end
      endcase
    end
  end

endmodule

//--- src/imuldiv_int_mul_iterative.sv
//--------------------------------------------------------------------------
// iterative signed multiplier
// shift-and-add on operand magnitudes, one bit per cycle, sign applied last
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imuldiv_int_mul_iterative (
  input  logic                       clk,
  input  logic                       reset,
  imuldiv_req_if.engine              req,
  output imuldiv_types_pkg::result_t resp_result,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  // control to datapath
  logic req_go;
  logic mag_en;
  logic calc_en;
  logic last_iter;

  // datapath registers
  imuldiv_types_pkg::result_t  a_reg;
  imuldiv_types_pkg::operand_t b_reg;
  imuldiv_types_pkg::result_t  acc_reg;
  logic                        sign_a_reg;
  logic                        sign_b_reg;

  // datapath combinational values
  imuldiv_types_pkg::operand_t a_mag;
  imuldiv_types_pkg::operand_t b_mag;
  imuldiv_types_pkg::result_t  acc_next;

  // control registers
  imuldiv_msg_pkg::engine_state_t state;
  imuldiv_types_pkg::count_t      count;
  logic                           load_pending;

  //--------------------------------------------------------------------------
  // datapath
  //--------------------------------------------------------------------------

  // magnitudes of the raw operands parked in the shift registers
  assign a_mag = sign_a_reg ? -a_reg[31:0] : a_reg[31:0];
  assign b_mag = sign_b_reg ? -b_reg : b_reg;

  // add the shifted multiplicand when the current multiplier bit is set
  assign acc_next = b_reg[0] ? acc_reg + a_reg : acc_reg;

  always_ff @(posedge clk) begin
    if (req_go) begin
      // raw operands and their signs land here on the accepting edge
      a_reg      <= {32'b0, req.a};
      b_reg      <= req.b;
      sign_a_reg <= req.a[31];
      sign_b_reg <= req.b[31];
    end else if (mag_en) begin
      // load cycle, keeps the negators off the request path
      a_reg   <= {32'b0, a_mag};
      b_reg   <= b_mag;
      acc_reg <= '0;
    end else if (calc_en) begin
      acc_reg <= acc_next;
      a_reg   <= a_reg << 1;
      b_reg   <= b_reg >> 1;
    end
  end

  // product is negative when exactly one operand was negative
  assign resp_result = (sign_a_reg ^ sign_b_reg) ? -acc_reg : acc_reg;

  //--------------------------------------------------------------------------
  // control
  //--------------------------------------------------------------------------

  assign req.rdy  = (state == imuldiv_msg_pkg::st_idle);
  assign resp_val = (state == imuldiv_msg_pkg::st_done);

  assign req_go    = req.val & req.rdy;
  assign mag_en    = (state == imuldiv_msg_pkg::st_calc) & load_pending;
  assign calc_en   = (state == imuldiv_msg_pkg::st_calc) & ~load_pending;
  assign last_iter = calc_en & (count == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= imuldiv_msg_pkg::st_idle;
      count        <= '0;
      load_pending <= 1'b0;
    end else begin
      case (state)
        imuldiv_msg_pkg::st_idle: begin
          if (req_go) begin
            state        <= imuldiv_msg_pkg::st_calc;
            load_pending <= 1'b1;
            // one iteration per operand bit
            count        <= imuldiv_types_pkg::count_t'(imuldiv_types_pkg::operand_width - 1);
          end
        end
        imuldiv_msg_pkg::st_calc: begin
          if (load_pending) begin
            load_pending <= 1'b0;
          end else if (last_iter) begin
            state <= imuldiv_msg_pkg::st_done;
          end else begin
            count <= count - imuldiv_types_pkg::count_t'(1);
          end
        end
        imuldiv_msg_pkg::st_done: begin
          // hold the product until the consumer takes it
          if (resp_rdy) begin
            state <= imuldiv_msg_pkg::st_idle;
          end
        end
        default: begin
          state <= imuldiv_msg_pkg::st_idle;
        end
      endcase
    end
  end

endmodule

//--- src/imuldiv_iterative_muldiv.sv
//--------------------------------------------------------------------------
// iterative multiply/divide unit
// steers one request at a time to its engine and returns the response
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imuldiv_iterative_muldiv (
  input  logic                        clk,
  input  logic                        reset,
  input  imuldiv_msg_pkg::fn_t        req_fn,
  input  imuldiv_types_pkg::operand_t req_a,
  input  imuldiv_types_pkg::operand_t req_b,
  input  logic                        req_val,
  output logic                        req_rdy,
  output imuldiv_types_pkg::result_t  resp_result,
  output logic                        resp_val,
  input  logic                        resp_rdy
);

  // one operation in flight, owner_div names the engine holding it
  logic busy;
  logic owner_div;

  logic req_is_div;
  logic req_go;
  logic resp_go;

  // engine response ports
  imuldiv_types_pkg::result_t mul_resp_result;
  logic                       mul_resp_val;
  logic                       mul_resp_rdy;
  imuldiv_types_pkg::result_t div_resp_result;
  logic                       div_resp_val;
  logic                       div_resp_rdy;

  imuldiv_req_if mul_req ();
  imuldiv_req_if div_req ();

  //--------------------------------------------------------------------------
  // request dispatch
  //--------------------------------------------------------------------------

  // anything that is not a multiply goes to the divider
  assign req_is_div = (req_fn != imuldiv_msg_pkg::fn_mul);

  // payload is broadcast, only val is steered
  assign mul_req.fn  = req_fn;
  assign mul_req.a   = req_a;
  assign mul_req.b   = req_b;
  assign mul_req.val = req_val & ~busy & ~req_is_div;

  assign div_req.fn  = req_fn;
  assign div_req.a   = req_a;
  assign div_req.b   = req_b;
  assign div_req.val = req_val & ~busy & req_is_div;

  // ready of the addressed engine, closed while an operation is pending
  assign req_rdy = ~busy & (req_is_div ? div_req.rdy : mul_req.rdy);

  assign req_go  = req_val & req_rdy;
  assign resp_go = resp_val & resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      owner_div <= 1'b0;
    end else begin
      if (req_go) begin
        busy      <= 1'b1;
        owner_div <= req_is_div;
      end else if (resp_go) begin
        busy <= 1'b0;
      end
    end
  end

  //--------------------------------------------------------------------------
  // engines
  //--------------------------------------------------------------------------

  imuldiv_int_mul_iterative i_imuldiv_int_mul_iterative (
    .clk         (clk),
    .reset       (reset),
    .req         (mul_req),
    .resp_result (mul_resp_result),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy)
  );

  imuldiv_int_div_iterative i_imuldiv_int_div_iterative (
    .clk         (clk),
    .reset       (reset),
    .req         (div_req),
    .resp_result (div_resp_result),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy)
  );

  //--------------------------------------------------------------------------
  // response merge
  //--------------------------------------------------------------------------

  // only the owner sees the consumer's ready, so order is kept
  assign mul_resp_rdy = resp_rdy & ~owner_div;
  assign div_resp_rdy = resp_rdy & owner_div;

  assign resp_val    = owner_div ? div_resp_val : mul_resp_val;
  assign resp_result = owner_div ? div_resp_result : mul_resp_result;

endmodule

//--- src/imuldiv_msg_pkg.sv
//--------------------------------------------------------------------------
// imuldiv message package
// function codes on the request and engine FSM state encoding
//--------------------------------------------------------------------------

package imuldiv_msg_pkg;

  //--------------------------------------------------------------------------
  // request function code
  //--------------------------------------------------------------------------

  // fn_mul   signed 32x32 multiply, full 64-bit product
  // fn_div   signed divide, truncates toward zero
  // fn_divu  unsigned divide
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } fn_t;

  //--------------------------------------------------------------------------
  // engine FSM states
  //--------------------------------------------------------------------------

  // st_fix is only visited by the divider
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_fix  = 2'd2,
    st_done = 2'd3
  } engine_state_t;

endpackage

//--- src/imuldiv_req_if.sv
//--------------------------------------------------------------------------
// imuldiv request interface
// one valid/ready request channel from the dispatcher to one engine
//--------------------------------------------------------------------------

`timescale 1ns/1ps

interface imuldiv_req_if;

  // request payload, only meaningful while val is high
  imuldiv_msg_pkg::fn_t        fn;
  imuldiv_types_pkg::operand_t a;
  imuldiv_types_pkg::operand_t b;

  // handshake, transfer on a rising edge with val and rdy both high
  logic                        val;
  logic                        rdy;

  // dispatcher side, owns the payload and val
  modport dispatch (
    output fn,
    output a,
    output b,
    output val,
    input  rdy
  );

  // engine side, only drives rdy back
  modport engine (
    input  fn,
    input  a,
    input  b,
    input  val,
    output rdy
  );

endinterface

//--- src/imuldiv_types_pkg.sv
//--------------------------------------------------------------------------
// imuldiv width package
// operand, result and iteration count widths for the muldiv unit
//--------------------------------------------------------------------------

package imuldiv_types_pkg;

  //--------------------------------------------------------------------------
  // widths
  //--------------------------------------------------------------------------

  // one source operand as seen on the request side
  localparam int operand_width = 32;

  // full product, or remainder in the high half and quotient in the low half
  localparam int result_width = 2 * operand_width;

  // enough bits to count one iteration per operand bit
  localparam int count_width = 5;

  //--------------------------------------------------------------------------
  // vector types
  //--------------------------------------------------------------------------

  // raw operand, signed or unsigned depending on the function code
  typedef logic [operand_width-1:0] operand_t;

  // response word
  typedef logic [result_width-1:0] result_t;

  // iteration counter, counts down to zero
  typedef logic [count_width-1:0] count_t;

endpackage

//--- test/imuldiv_checker.sv
//--------------------------------------------------------------------------
// muldiv handshake checker
// concurrent assertions on the top-level ports, bound to the DUT
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imuldiv_checker (
  input logic                       clk,
  input logic                       reset,
  input logic                       req_rdy,
  input imuldiv_types_pkg::result_t resp_result,
  input logic                       resp_val,
  input logic                       resp_rdy
);

  // failed assertions, read back by the testbench
  int fail_count = 0;

  // a pending response is held until it is taken
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val)
    else begin
      $error("resp_val dropped before resp_rdy");
      fail_count++;
    end

  a_resp_stable: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> $stable(resp_result))
    else begin
      $error("resp_result changed while stalled");
      fail_count++;
    end

  // strictly iterative, nothing is accepted with a response pending
  a_no_req: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> !req_rdy)
    else begin
      $error("req_rdy high while resp_val is high");
      fail_count++;
    end

  a_reset_idle: assert property (@(posedge clk) reset |=> !resp_val)
    else begin
      $error("resp_val high in the cycle after reset");
      fail_count++;
    end

endmodule

//--- test/imuldiv_monitor.sv
//--------------------------------------------------------------------------
// muldiv monitor
// watches the DUT ports, checks results, order and latency, counts errors
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imuldiv_monitor (
  input logic                        clk,
  input logic                        reset,
  input imuldiv_msg_pkg::fn_t        req_fn,
  input imuldiv_types_pkg::operand_t req_a,
  input imuldiv_types_pkg::operand_t req_b,
  input logic                        req_val,
  input logic                        req_rdy,
  input imuldiv_types_pkg::result_t  resp_result,
  input logic                        resp_val,
  input logic                        resp_rdy
);

  // expected values in request order, has_exp clear means compute here
  imuldiv_types_pkg::result_t exp_fifo [0:7];
  logic                       has_fifo [0:7];
  logic [2:0]                 wr_ptr = '0;
  logic [2:0]                 rd_ptr = '0;

  int error_count = 0;
  int resp_count  = 0;
  int cycle       = 0;
  int acc_cycle   = 0;
  logic pending    = 1'b0;
  logic resp_val_q = 1'b0;

  // operation captured at the accepting edge
  imuldiv_msg_pkg::fn_t        cur_fn;
  imuldiv_types_pkg::operand_t cur_a;
  imuldiv_types_pkg::operand_t cur_b;
  imuldiv_types_pkg::result_t  expected;

  task push_expected(input imuldiv_types_pkg::result_t e, input logic h);
    exp_fifo[wr_ptr] = e;
    has_fifo[wr_ptr] = h;
    wr_ptr = wr_ptr + 3'd1;
  endtask

  // reference result from the arithmetic rules of the unit
  function automatic imuldiv_types_pkg::result_t model(input imuldiv_msg_pkg::fn_t fn,
                                                       input imuldiv_types_pkg::operand_t a,
                                                       input imuldiv_types_pkg::operand_t b);
    imuldiv_types_pkg::operand_t ma;
    imuldiv_types_pkg::operand_t mb;
    imuldiv_types_pkg::operand_t q;
    imuldiv_types_pkg::operand_t r;
    logic                        sgn;
    if (fn == imuldiv_msg_pkg::fn_mul) begin
      return imuldiv_types_pkg::result_t'(longint'(signed'(a)) * longint'(signed'(b)));
    end
    sgn = (fn == imuldiv_msg_pkg::fn_div);
    ma = (sgn && a[31]) ? -a : a;
    mb = (sgn && b[31]) ? -b : b;
    // divide by zero: all-ones quotient, dividend as remainder
    q = (mb == '0) ? '1 : ma / mb;
    r = (mb == '0) ? ma : ma % mb;
    if (sgn && (a[31] ^ b[31])) begin
      q = -q;
    end
    if (sgn && a[31]) begin
      r = -r;
    end
    return {r, q};
  endfunction

  task report();
    $display("responses %0d, errors %0d", resp_count, error_count);
  endtask

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (!reset) begin
      if (req_val && req_rdy) begin
        if (pending) begin
          $display("request accepted at %0t while an operation is pending", $time);
          error_count++;
        end
        pending   = 1'b1;
        cur_fn    = req_fn;
        cur_a     = req_a;
        cur_b     = req_b;
        acc_cycle = cycle;
      end
      // resp_val rose on the previous edge
      if (resp_val && !resp_val_q && pending) begin
        if ((cycle - 1 - acc_cycle) != ((cur_fn == imuldiv_msg_pkg::fn_mul) ? 33 : 34)) begin
          $display("Error: time %0t resp_val latency expected %0d actual %0d", $time,
                   (cur_fn == imuldiv_msg_pkg::fn_mul) ? 33 : 34, cycle - 1 - acc_cycle);
          error_count++;
        end
      end
      if (resp_val && resp_rdy) begin
        if (!pending || rd_ptr == wr_ptr) begin
          $display("response at %0t without a pending request", $time);
          error_count++;
        end else begin
          expected = has_fifo[rd_ptr] ? exp_fifo[rd_ptr] : model(cur_fn, cur_a, cur_b);
          if (resp_result !== expected) begin
            $display("Error: time %0t resp_result expected %h actual %h", $time,
                     expected, resp_result);
            error_count++;
          end
          rd_ptr = rd_ptr + 3'd1;
        end
        resp_count++;
        pending = 1'b0;
      end
    end
    resp_val_q = resp_val;
  end

endmodule

//--- test/imuldiv_tb.sv
//--------------------------------------------------------------------------
// muldiv testbench
// directed table then LFSR operands, random response stalls, timeout
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imuldiv_tb;

  localparam int n_table   = 18;
  localparam int n_random  = 16;
  localparam int n_entries = n_table + n_random;
  // per entry: compute, worst stall and handshake slack
  localparam int timeout_cycles = n_entries * (34 + 3 + 4) + 10;

  typedef struct packed {
    imuldiv_msg_pkg::fn_t        fn;
    imuldiv_types_pkg::operand_t a;
    imuldiv_types_pkg::operand_t b;
    imuldiv_types_pkg::result_t  exp;
  } vector_t;

  logic                        clk;
  logic                        reset;
  imuldiv_msg_pkg::fn_t        req_fn;
  imuldiv_types_pkg::operand_t req_a;
  imuldiv_types_pkg::operand_t req_b;
  logic                        req_val;
  logic                        req_rdy;
  imuldiv_types_pkg::result_t  resp_result;
  logic                        resp_val;
  logic                        resp_rdy;

  vector_t     vectors [0:n_table-1];
  logic [15:0] lfsr = 16'd96;
  int          cycles = 0;

  imuldiv_iterative_muldiv i_imuldiv_iterative_muldiv (.*);

  imuldiv_monitor i_imuldiv_monitor (.*);

  bind imuldiv_iterative_muldiv imuldiv_checker i_imuldiv_checker (
    .clk         (clk),
    .reset       (reset),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // 16-bit Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one LFSR step per bit taken
  task take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[15]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task run_entry(input vector_t e, input logic has_exp);
    logic [31:0] bits;
    int          stall;
    take_bits(2, bits);
    stall = int'(bits[1:0]);
    i_imuldiv_monitor.push_expected(e.exp, has_exp);
    req_fn  <= e.fn;
    req_a   <= e.a;
    req_b   <= e.b;
    req_val <= 1'b1;
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
    // request stays presented while the operation runs, it must not be taken twice
    if (stall != 0) begin
      resp_rdy <= 1'b0;
    end
    @(posedge clk);
    while (!resp_val) @(posedge clk);
    // with no stall the response was taken on this edge
    if (stall != 0) begin
      repeat (stall - 1) @(posedge clk);
      resp_rdy <= 1'b1;
      @(posedge clk);
    end
  endtask

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout waiting for response");
      i_imuldiv_monitor.report();
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    vector_t     e;
    logic [31:0] bits;
    reset    = 1'b1;
    req_fn   = imuldiv_msg_pkg::fn_mul;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    // multiply, all sign combinations and extremes
    vectors[0]  = '{imuldiv_msg_pkg::fn_mul,  32'd6,        32'd7,        64'd42};
    vectors[1]  = '{imuldiv_msg_pkg::fn_mul,  32'hFFFFFFFA, 32'd7,        64'hFFFFFFFF_FFFFFFD6};
    vectors[2]  = '{imuldiv_msg_pkg::fn_mul,  32'd6,        32'hFFFFFFF9, 64'hFFFFFFFF_FFFFFFD6};
    vectors[3]  = '{imuldiv_msg_pkg::fn_mul,  32'hFFFFFFFA, 32'hFFFFFFF9, 64'd42};
    vectors[4]  = '{imuldiv_msg_pkg::fn_mul,  32'd0,        32'd12345,    64'd0};
    vectors[5]  = '{imuldiv_msg_pkg::fn_mul,  32'h80000000, 32'hFFFFFFFF, 64'h00000000_80000000};
    vectors[6]  = '{imuldiv_msg_pkg::fn_mul,  32'h7FFFFFFF, 32'h7FFFFFFF, 64'h3FFFFFFF_00000001};
    // signed divide, remainder high and quotient low
    vectors[7]  = '{imuldiv_msg_pkg::fn_div,  32'd7,        32'd2,        64'h00000001_00000003};
    vectors[8]  = '{imuldiv_msg_pkg::fn_div,  32'hFFFFFFF9, 32'd2,        64'hFFFFFFFF_FFFFFFFD};
    vectors[9]  = '{imuldiv_msg_pkg::fn_div,  32'd7,        32'hFFFFFFFE, 64'h00000001_FFFFFFFD};
    vectors[10] = '{imuldiv_msg_pkg::fn_div,  32'hFFFFFFF9, 32'hFFFFFFFE, 64'hFFFFFFFF_00000003};
    vectors[11] = '{imuldiv_msg_pkg::fn_div,  32'd0,        32'd5,        64'd0};
    vectors[12] = '{imuldiv_msg_pkg::fn_div,  32'd5,        32'd0,        64'h00000005_FFFFFFFF};
    vectors[13] = '{imuldiv_msg_pkg::fn_div,  32'hFFFFFFFB, 32'd0,        64'hFFFFFFFB_00000001};
    vectors[14] = '{imuldiv_msg_pkg::fn_div,  32'h80000000, 32'hFFFFFFFF, 64'h00000000_80000000};
    // unsigned divide with the top bit set
    vectors[15] = '{imuldiv_msg_pkg::fn_divu, 32'd5,        32'd0,        64'h00000005_FFFFFFFF};
    vectors[16] = '{imuldiv_msg_pkg::fn_divu, 32'hFFFFFFFF, 32'd2,        64'h00000001_7FFFFFFF};
    vectors[17] = '{imuldiv_msg_pkg::fn_divu, 32'h80000000, 32'd3,        64'h00000002_2AAAAAAA};
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < n_entries; i++) begin
      if (i < n_table) begin
        run_entry(vectors[i], 1'b1);
      end else begin
        take_bits(2, bits);
        // code 3 is unused, fold it onto multiply
        e.fn = (bits[1:0] == 2'd3) ? imuldiv_msg_pkg::fn_mul : imuldiv_msg_pkg::fn_t'(bits[1:0]);
        take_bits(32, bits);
        e.a = bits;
        take_bits(32, bits);
        e.b = bits;
        e.exp = '0;
        run_entry(e, 1'b0);
      end
    end
    req_val <= 1'b0;
    @(posedge clk);
    i_imuldiv_monitor.report();
    if (i_imuldiv_monitor.error_count == 0 && i_imuldiv_monitor.resp_count == n_entries &&
        i_imuldiv_iterative_muldiv.i_imuldiv_checker.fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
